// File: sys_svc_pkg.sv
// bus widths, AHB encodings, master FSM state type and bus address union

`default_nettype none

package sys_svc_pkg;

   // ---------------------------------------------------------------------
   // bus widths
   // ---------------------------------------------------------------------
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // ---------------------------------------------------------------------
   // AHB encodings
   // ---------------------------------------------------------------------

   // transfer type, only IDLE and NONSEQ leave this master
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_t;

   // every transfer is one 32-bit word
   localparam logic [2:0] HSIZE_WORD    = 3'b010;
   localparam logic [2:0] HBURST_SINGLE = 3'b000;

   // slave response
   localparam logic HRESP_OKAY  = 1'b0;
   localparam logic HRESP_ERROR = 1'b1;

   // ---------------------------------------------------------------------
   // master FSM
   // ---------------------------------------------------------------------

   // one pass of BREQ, ADDR, DATA per word
   typedef enum logic [2:0] {
      ST_IDLE = 3'd0,
      ST_BREQ = 3'd1,
      ST_ADDR = 3'd2,
      ST_DATA = 3'd3,
      ST_DONE = 3'd4
   } fsm_state_t;

   // ---------------------------------------------------------------------
   // bus address
   // ---------------------------------------------------------------------

   // raw byte address, or word index plus byte offset
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      struct packed {
         logic [ADDR_W-3:0] word_idx;
         logic [1:0]        byte_off;
      } part;
   } ahb_addr_u;

endpackage

`default_nettype wire

// File: xfer_if.sv
// control strobes between the master FSM, address generator and word counter

`timescale 1ns/1ps
`default_nettype none

interface xfer_if;

   // start of a transaction, one cycle in the accepting IDLE cycle
   logic load;
   // source base selected, valid with load
   logic use_src;
   // write transaction, valid with load
   logic is_write;
   // data phase finished with OKAY
   logic beat_ok;
   // one word left in the counter
   logic last;

   // FSM side
   modport ctrl (output load, output use_src, output is_write, output beat_ok,
                 input last);

   // address generator side
   modport addr (input load, input use_src, input beat_ok);

   // word counter side
   modport cnt (input load, input is_write, input beat_ok, output last);

endinterface

`default_nettype wire

// File: ahb_master_fsm.sv
// AHB-Lite master control FSM with bus control outputs, strobes and done pulses

`timescale 1ns/1ps
`default_nettype none

module ahb_master_fsm (
   input  logic                 hclk,
   input  logic                 hresetn,
   // AHB side
   input  logic                 hready_i,
   input  logic                 hresp_i,
   input  logic                 hgrant_i,
   // request levels from the command decoder
   input  logic                 rd_resp_i,
   input  logic                 rd_req_i,
   input  logic                 rd_async_i,
   input  logic                 wr_req_i,
   // bus control
   output logic                 busreq_o,
   output sys_svc_pkg::htrans_t htrans_o,
   output logic                 hwrite_o,
   output logic                 hsel_o,
   // decoder strobes and pulses
   output logic                 push_o,
   output logic                 pop_o,
   output logic                 done_o,
   output logic                 rvalid_o,
   output logic                 clr_req_o,
   // datapath control
   xfer_if.ctrl                 xfer
);

   sys_svc_pkg::fsm_state_t state_q;
   sys_svc_pkg::fsm_state_t state_d;

   // kind of the running transaction, high for a write
   logic wr_q;
   logic clr_q;

   logic rd_any;
   logic req_any;
   logic accept;
   logic data_ok;
   logic data_err;

   // ---------------------------------------------------------------------
   // request decode
   // ---------------------------------------------------------------------

   // any read kind beats a pending write
   assign rd_any  = rd_resp_i | rd_req_i | rd_async_i;
   assign req_any = rd_any | wr_req_i;
   assign accept  = (state_q == sys_svc_pkg::ST_IDLE) && req_any;

   // data phase outcome
   assign data_ok  = (state_q == sys_svc_pkg::ST_DATA) && hready_i &&
                     (hresp_i == sys_svc_pkg::HRESP_OKAY);
   // first cycle of the two-cycle ERROR response
   assign data_err = (state_q == sys_svc_pkg::ST_DATA) && !hready_i &&
                     (hresp_i == sys_svc_pkg::HRESP_ERROR);

   // ---------------------------------------------------------------------
   // state register
   // ---------------------------------------------------------------------
   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn) begin
         state_q <= sys_svc_pkg::ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // kind flag and clear-request pulse
   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn) begin
         wr_q  <= 1'b0;
         clr_q <= 1'b0;
      end else begin
         // decoder drops its level one cycle after acceptance
         clr_q <= accept;
         if (accept) begin
            wr_q <= !rd_any;
         end
      end
   end

   // ---------------------------------------------------------------------
   // next state
   // ---------------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         sys_svc_pkg::ST_IDLE: begin
            if (req_any) begin
               state_d = sys_svc_pkg::ST_BREQ;
            end
         end
         sys_svc_pkg::ST_BREQ: begin
            // bus owned and previous transfer finished
            if (hgrant_i && hready_i) begin
               state_d = sys_svc_pkg::ST_ADDR;
            end
         end
         sys_svc_pkg::ST_ADDR: begin
            state_d = sys_svc_pkg::ST_DATA;
         end
         sys_svc_pkg::ST_DATA: begin
            if (data_ok) begin
               // re-arbitrate for every word
               state_d = xfer.last ? sys_svc_pkg::ST_DONE : sys_svc_pkg::ST_BREQ;
            end else if (data_err) begin
               // abort, no strobe and no done
               state_d = sys_svc_pkg::ST_IDLE;
            end
         end
         sys_svc_pkg::ST_DONE: begin
            state_d = sys_svc_pkg::ST_IDLE;
         end
         default: begin
            state_d = sys_svc_pkg::ST_IDLE;
         end
      endcase
   end

   // ---------------------------------------------------------------------
   // bus control outputs
   // ---------------------------------------------------------------------

   // request raised in the accepting cycle already
   assign busreq_o = accept || (state_q == sys_svc_pkg::ST_BREQ);

   // single NONSEQ per word, IDLE otherwise
   assign htrans_o = (state_q == sys_svc_pkg::ST_ADDR) ? sys_svc_pkg::NONSEQ
                                                       : sys_svc_pkg::IDLE;
   assign hwrite_o = (state_q == sys_svc_pkg::ST_ADDR) && wr_q;
   assign hsel_o   = (state_q != sys_svc_pkg::ST_IDLE);

   // ---------------------------------------------------------------------
   // decoder strobes
   // ---------------------------------------------------------------------
   assign push_o    = data_ok && !wr_q;
   assign pop_o     = data_ok && wr_q;
   assign done_o    = (state_q == sys_svc_pkg::ST_DONE);
   // read data complete for the decoder
   assign rvalid_o  = done_o && !wr_q;
   assign clr_req_o = clr_q;

   // ---------------------------------------------------------------------
   // datapath control
   // ---------------------------------------------------------------------
   assign xfer.load     = accept;
   // response and async reads start at the source address
   assign xfer.use_src  = rd_resp_i | rd_async_i;
   assign xfer.is_write = !rd_any;
   assign xfer.beat_ok  = data_ok;

endmodule

`default_nettype wire

// File: addr_gen.sv
// bus address generator with base selection, latching and word increment

`timescale 1ns/1ps
`default_nettype none

module addr_gen (
   input  logic                   hclk,
   input  logic                   hresetn,
   // base addresses from the command decoder
   input  sys_svc_pkg::ahb_addr_u src_addr_i,
   input  sys_svc_pkg::ahb_addr_u dst_addr_i,
   // registered bus address
   output sys_svc_pkg::ahb_addr_u haddr_o,
   // strobes from the FSM
   xfer_if.addr                   xfer
);

   sys_svc_pkg::ahb_addr_u base;

   // ---------------------------------------------------------------------
   // base selection
   // ---------------------------------------------------------------------

   // src for response and async reads, dst for request reads and writes
   assign base = xfer.use_src ? src_addr_i : dst_addr_i;

   // ---------------------------------------------------------------------
   // address register
   // ---------------------------------------------------------------------
   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn) begin
         haddr_o.raw <= '0;
      end else begin
         if (xfer.load) begin
            // word aligned, low bits dropped
            haddr_o.part.word_idx <= base.part.word_idx;
            haddr_o.part.byte_off <= 2'b00;
         end else if (xfer.beat_ok) begin
            // next word, 4 bytes on
            haddr_o.part.word_idx <= haddr_o.part.word_idx + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: word_counter.sv
// transfer length counter with load, decrement and last-word flag

`timescale 1ns/1ps
`default_nettype none

module word_counter #(
   parameter int CNT_W = 16
) (
   input  logic             hclk,
   input  logic             hresetn,
   // lengths in words from the command decoder
   input  logic [CNT_W-1:0] len_rd_i,
   input  logic [CNT_W-1:0] len_wr_i,
   // strobes from the FSM
   xfer_if.cnt              xfer
);

   // words still to transfer
   logic [CNT_W-1:0] count_q;

   // ---------------------------------------------------------------------
   // count register
   // ---------------------------------------------------------------------
   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn) begin
         count_q <= '0;
      end else begin
         if (xfer.load) begin
            count_q <= xfer.is_write ? len_wr_i : len_rd_i;
         end else if (xfer.beat_ok) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // the word in flight is the final one
   assign xfer.last = (count_q == CNT_W'(1));

endmodule

`default_nettype wire

// File: sys_svc_ahb_master.sv
// system-services AHB-Lite master top level with FSM, address and count datapath

`timescale 1ns/1ps
`default_nettype none

module sys_svc_ahb_master #(
   parameter int CNT_W = 16
) (
   input  logic                           hclk,
   input  logic                           hresetn,
   // AHB-Lite slave side
   input  logic                           hready_i,
   input  logic                           hresp_i,
   input  logic                           hgrant_i,
   input  logic [sys_svc_pkg::DATA_W-1:0] hrdata_i,
   // command decoder side
   input  logic [sys_svc_pkg::ADDR_W-1:0] src_addr_i,
   input  logic [sys_svc_pkg::ADDR_W-1:0] dst_addr_i,
   input  logic [CNT_W-1:0]               len_rd_i,
   input  logic [CNT_W-1:0]               len_wr_i,
   input  logic                           rd_resp_i,
   input  logic                           rd_req_i,
   input  logic                           rd_async_i,
   input  logic                           wr_req_i,
   input  logic [sys_svc_pkg::DATA_W-1:0] wdata_i,
   // AHB-Lite master outputs
   output logic [1:0]                     htrans_o,
   output logic                           hwrite_o,
   output logic [2:0]                     hsize_o,
   output logic [2:0]                     hburst_o,
   output logic                           hsel_o,
   output logic [sys_svc_pkg::ADDR_W-1:0] haddr_o,
   output logic [sys_svc_pkg::DATA_W-1:0] hwdata_o,
   output logic                           busreq_o,
   // command decoder outputs
   output logic [sys_svc_pkg::DATA_W-1:0] rdata_o,
   output logic                           push_o,
   output logic                           pop_o,
   output logic                           done_o,
   output logic                           rvalid_o,
   output logic                           clr_req_o
);

   sys_svc_pkg::htrans_t   htrans;
   sys_svc_pkg::ahb_addr_u src_addr;
   sys_svc_pkg::ahb_addr_u dst_addr;
   sys_svc_pkg::ahb_addr_u haddr;

   xfer_if xfer ();

   // ---------------------------------------------------------------------
   // fixed fields and data paths
   // ---------------------------------------------------------------------
   assign hsize_o  = sys_svc_pkg::HSIZE_WORD;
   assign hburst_o = sys_svc_pkg::HBURST_SINGLE;
   // write data straight from the decoder FIFO, read data straight back
   assign hwdata_o = wdata_i;
   assign rdata_o  = hrdata_i;

   // plain ports in and out of the address union
   assign src_addr.raw = src_addr_i;
   assign dst_addr.raw = dst_addr_i;
   assign haddr_o      = haddr.raw;
   assign htrans_o     = htrans;

   // ---------------------------------------------------------------------
   // control FSM
   // ---------------------------------------------------------------------
   ahb_master_fsm u_fsm (
      .hclk       (hclk),
      .hresetn    (hresetn),
      .hready_i   (hready_i),
      .hresp_i    (hresp_i),
      .hgrant_i   (hgrant_i),
      .rd_resp_i  (rd_resp_i),
      .rd_req_i   (rd_req_i),
      .rd_async_i (rd_async_i),
      .wr_req_i   (wr_req_i),
      .busreq_o   (busreq_o),
      .htrans_o   (htrans),
      .hwrite_o   (hwrite_o),
      .hsel_o     (hsel_o),
      .push_o     (push_o),
      .pop_o      (pop_o),
      .done_o     (done_o),
      .rvalid_o   (rvalid_o),
      .clr_req_o  (clr_req_o),
      .xfer       (xfer.ctrl)
   );

   // ---------------------------------------------------------------------
   // datapath
   // ---------------------------------------------------------------------
   addr_gen u_addr_gen (
      .hclk       (hclk),
      .hresetn    (hresetn),
      .src_addr_i (src_addr),
      .dst_addr_i (dst_addr),
      .haddr_o    (haddr),
      .xfer       (xfer.addr)
   );

   word_counter #(
      .CNT_W (CNT_W)
   ) u_word_counter (
      .hclk     (hclk),
      .hresetn  (hresetn),
      .len_rd_i (len_rd_i),
      .len_wr_i (len_wr_i),
      .xfer     (xfer.cnt)
   );

endmodule

`default_nettype wire

// File: tb_sys_svc_ahb_master.sv
// testbench for the AHB master with slave model, decoder model, table-driven checks and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_sys_svc_ahb_master;

   localparam int CNT_W     = 16;
   localparam int MAX_LINES = 32;
   localparam int DW        = sys_svc_pkg::DATA_W;

   logic hclk;
   logic hresetn;
   logic hready_i;
   logic hresp_i;
   logic hgrant_i;
   logic [DW-1:0] hrdata_i;
   logic [DW-1:0] wdata_i;
   logic [31:0] src_addr_i;
   logic [31:0] dst_addr_i;
   logic [CNT_W-1:0] len_rd_i;
   logic [CNT_W-1:0] len_wr_i;
   logic rd_resp_i;
   logic rd_req_i;
   logic rd_async_i;
   logic wr_req_i;
   logic [1:0] htrans_o;
   logic [2:0] hsize_o;
   logic [2:0] hburst_o;
   logic [31:0] haddr_o;
   logic [DW-1:0] hwdata_o;
   logic [DW-1:0] rdata_o;
   logic hwrite_o;
   logic hsel_o;
   logic busreq_o;
   logic push_o;
   logic pop_o;
   logic done_o;
   logic rvalid_o;
   logic clr_req_o;

   integer seed = 32'h7f19_6c86;

   // slave memory of 256 words
   logic [DW-1:0] mem [0:255];
   logic [DW-1:0] wdata_cur;

   // kind codes 0 write, 1 request read, 2 response read, 3 async read, 4 read then write
   int kind_q [$];
   int cur_kind;
   int cur_wait;
   int cur_err;
   int cur_len_rd;
   int cur_len_wr;
   logic [31:0] cur_src;
   logic [31:0] cur_dst;
   int beat;
   int txn_no;
   int wait_left;
   int err_step;
   int strobes;
   int dones;
   int ends;
   int clr_cnt;
   int n_checks;
   int n_errors;
   int limit_ns;
   // bus requested and granted in the previous cycle
   logic granted_q;

   // stimulus table with one row per file line
   int n_lines;
   int t_kind [MAX_LINES];
   logic [31:0] t_src [MAX_LINES];
   logic [31:0] t_dst [MAX_LINES];
   int t_len_rd [MAX_LINES];
   int t_len_wr [MAX_LINES];
   int t_wait [MAX_LINES];
   int t_err [MAX_LINES];
   int t_strobes [MAX_LINES];
   int t_dones [MAX_LINES];

   sys_svc_ahb_master #(.CNT_W(CNT_W)) uut (
      .hclk(hclk), .hresetn(hresetn), .hready_i(hready_i), .hresp_i(hresp_i),
      .hgrant_i(hgrant_i), .hrdata_i(hrdata_i), .src_addr_i(src_addr_i),
      .dst_addr_i(dst_addr_i), .len_rd_i(len_rd_i), .len_wr_i(len_wr_i),
      .rd_resp_i(rd_resp_i), .rd_req_i(rd_req_i), .rd_async_i(rd_async_i),
      .wr_req_i(wr_req_i), .wdata_i(wdata_i), .htrans_o(htrans_o), .hwrite_o(hwrite_o),
      .hsize_o(hsize_o), .hburst_o(hburst_o), .hsel_o(hsel_o), .haddr_o(haddr_o),
      .hwdata_o(hwdata_o), .busreq_o(busreq_o), .rdata_o(rdata_o), .push_o(push_o),
      .pop_o(pop_o), .done_o(done_o), .rvalid_o(rvalid_o), .clr_req_o(clr_req_o)
   );

   always #4 hclk = ~hclk;

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------
   task automatic check_addr(input sys_svc_pkg::ahb_addr_u got,
                             input sys_svc_pkg::ahb_addr_u exp, input string what);
      n_checks++;
      if (got.raw !== exp.raw) begin
         n_errors++;
         $display("** Error at %0t ns: %s got %h expected %h", $time, what, got.raw, exp.raw);
      end
   endtask

   task automatic check_data(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                             input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_trans(input sys_svc_pkg::htrans_t got,
                              input sys_svc_pkg::htrans_t exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("** Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input integer got, input integer exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("** Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // response and async reads start at src and the others at dst
   function automatic logic [31:0] base_of(input int kind);
      base_of = (kind == 2 || kind == 3) ? cur_src : cur_dst;
   endfunction

   function automatic int len_of(input int kind);
      len_of = (kind == 0) ? cur_len_wr : cur_len_rd;
   endfunction

   // ----------------------------------------------------------------------
   // bus monitor, slave and decoder model
   // ----------------------------------------------------------------------
   always @(posedge hclk) begin : bus_model
      sys_svc_pkg::ahb_addr_u exp_a;
      sys_svc_pkg::ahb_addr_u got_a;
      logic is_wr;
      logic req_lvl;
      req_lvl = rd_resp_i || rd_req_i || rd_async_i || wr_req_i;
      // accepted transaction makes the decoder drop its level
      if (clr_req_o) begin
         if (kind_q.size() == 0) begin
            n_errors++;
            $display("clear request seen with no transaction pending at %0t ns", $time);
         end else begin
            cur_kind = kind_q.pop_front();
         end
         beat = 0;
         txn_no = clr_cnt;
         clr_cnt++;
         if (rd_resp_i || rd_req_i || rd_async_i) begin
            rd_resp_i <= 1'b0;
            rd_req_i <= 1'b0;
            rd_async_i <= 1'b0;
         end else begin
            wr_req_i <= 1'b0;
         end
      end
      is_wr = (cur_kind == 0);
      exp_a.raw = base_of(cur_kind) + 32'(4 * beat);
      got_a.raw = haddr_o;
      if (!hsel_o) begin
         check_trans(sys_svc_pkg::htrans_t'(htrans_o), sys_svc_pkg::IDLE, "htrans when idle");
         // an idle master requests the bus as soon as a level is raised
         check_count(busreq_o, req_lvl, "busreq when idle");
      end
      if (htrans_o == sys_svc_pkg::NONSEQ) begin
         check_addr(got_a, exp_a, "address phase");
         check_count(hwrite_o, is_wr, "hwrite in address phase");
         // one word per transfer, single burst
         check_count(hsize_o, 3'b010, "hsize in address phase");
         check_count(hburst_o, 3'b000, "hburst in address phase");
         check_count(granted_q, 1, "bus request and grant before address phase");
      end
      if (push_o) begin
         check_count(is_wr, 0, "push during a write");
         check_data(rdata_o, mem[exp_a.part.word_idx[7:0]], "read data");
         strobes++;
         beat++;
      end
      if (pop_o) begin
         check_count(is_wr, 1, "pop during a read");
         check_data(hwdata_o, wdata_cur, "write data");
         mem[exp_a.part.word_idx[7:0]] = hwdata_o;
         strobes++;
         beat++;
         // decoder FIFO offers the next word
         wdata_cur = $random(seed);
         wdata_i <= wdata_cur;
      end
      if (done_o) begin
         check_count(beat, len_of(cur_kind), "words before done");
         check_count(rvalid_o, !is_wr, "rvalid with done");
         dones++;
         ends++;
      end else begin
         check_count(rvalid_o, 0, "rvalid without done");
      end
      // first cycle of an ERROR response ends the transaction
      if (hsel_o && !hready_i && hresp_i == sys_svc_pkg::HRESP_ERROR) begin
         ends++;
      end
      // slave response with a two-cycle ERROR or random wait states
      if (err_step == 1) begin
         hready_i <= 1'b1;
         err_step = 2;
      end else if (err_step == 2) begin
         hresp_i <= sys_svc_pkg::HRESP_OKAY;
         err_step = 0;
      end else if (htrans_o == sys_svc_pkg::NONSEQ) begin
         if (beat == cur_err && txn_no == 0) begin
            hready_i <= 1'b0;
            hresp_i <= sys_svc_pkg::HRESP_ERROR;
            err_step = 1;
         end else begin
            wait_left = $unsigned($random(seed)) % (cur_wait + 1);
            hready_i <= (wait_left == 0);
            hrdata_i <= mem[got_a.part.word_idx[7:0]];
         end
      end else if (!hready_i) begin
         wait_left--;
         hready_i <= (wait_left == 0);
      end
      // arbiter grants at once only in zero-wait runs
      hgrant_i <= (cur_wait == 0) || (($random(seed) & 1) != 0);
      granted_q = busreq_o && hgrant_i;
   end

   // ----------------------------------------------------------------------
   // stimulus table and sequencing
   // ----------------------------------------------------------------------
   task automatic load_table(output bit ok);
      int fd;
      int n;
      int k;
      int lr;
      int lw;
      int w;
      int e;
      int ns;
      int nd;
      logic [31:0] s;
      logic [31:0] d;
      string line;
      int limit;
      ok = 0;
      n_lines = 0;
      limit = 2000;
      fd = $fopen("sys_svc_stimulus.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin
               n = $sscanf(line, "%d %h %h %d %d %d %d %d %d", k, s, d, lr, lw, w, e, ns, nd);
               if (n == 9) begin
                  t_kind[n_lines] = k;
                  t_src[n_lines] = s;
                  t_dst[n_lines] = d;
                  t_len_rd[n_lines] = lr;
                  t_len_wr[n_lines] = lw;
                  t_wait[n_lines] = w;
                  t_err[n_lines] = e;
                  t_strobes[n_lines] = ns;
                  t_dones[n_lines] = nd;
                  // worst case per word plus slack per line
                  limit += (lr + lw) * (w + 6) * 8 + 200;
                  n_lines++;
               end
            end
         end
         $fclose(fd);
         ok = (n_lines > 0);
      end
      limit_ns = limit;
   endtask

   task automatic run_line(input int i);
      int n_txn;
      @(posedge hclk);
      n_txn = (t_kind[i] == 4) ? 2 : 1;
      strobes = 0;
      dones = 0;
      ends = 0;
      clr_cnt = 0;
      cur_src = t_src[i];
      cur_dst = t_dst[i];
      cur_len_rd = t_len_rd[i];
      cur_len_wr = t_len_wr[i];
      cur_wait = t_wait[i];
      cur_err = t_err[i];
      if (t_kind[i] == 4) begin
         kind_q.push_back(2);
         kind_q.push_back(0);
      end else begin
         kind_q.push_back(t_kind[i]);
      end
      src_addr_i <= t_src[i];
      dst_addr_i <= t_dst[i];
      len_rd_i <= CNT_W'(t_len_rd[i]);
      len_wr_i <= CNT_W'(t_len_wr[i]);
      wr_req_i <= (t_kind[i] == 0 || t_kind[i] == 4);
      rd_req_i <= (t_kind[i] == 1);
      rd_resp_i <= (t_kind[i] == 2 || t_kind[i] == 4);
      rd_async_i <= (t_kind[i] == 3);
      // done or abort ends each transaction
      while (ends < n_txn) begin
         @(posedge hclk);
      end
      repeat (3) @(posedge hclk);
      check_count(strobes, t_strobes[i], "strobe count");
      check_count(dones, t_dones[i], "done count");
      check_count(clr_cnt, n_txn, "clear-request pulses");
      check_count(hsel_o, 0, "hsel after transaction");
   endtask

   initial begin : main
      bit ok;
      int i;
      hclk = 1'b0;
      hresetn = 1'b0;
      hready_i = 1'b1;
      hresp_i = sys_svc_pkg::HRESP_OKAY;
      hgrant_i = 1'b0;
      hrdata_i = '0;
      src_addr_i = '0;
      dst_addr_i = '0;
      len_rd_i = '0;
      len_wr_i = '0;
      rd_resp_i = 1'b0;
      rd_req_i = 1'b0;
      rd_async_i = 1'b0;
      wr_req_i = 1'b0;
      cur_kind = 0;
      cur_wait = 0;
      cur_err = 99;
      beat = 0;
      txn_no = 0;
      wait_left = 0;
      err_step = 0;
      granted_q = 1'b0;
      n_checks = 0;
      n_errors = 0;
      for (i = 0; i < 256; i++) begin
         mem[i] = $random(seed);
      end
      wdata_cur = $random(seed);
      wdata_i = wdata_cur;
      load_table(ok);
      if (!ok) begin
         $display("stimulus file missing or holds no valid line");
         $display("Some tests failed");
         $finish;
      end else begin
         repeat (3) @(posedge hclk);
         hresetn <= 1'b1;
         for (i = 0; i < n_lines; i++) begin
            run_line(i);
         end
         $display("checks: %0d, errors: %0d", n_checks, n_errors);
         if (n_errors == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
         $finish;
      end
   end

   // ends a run where the DUT stops completing transactions
   initial begin : watchdog
      wait (limit_ns > 0);
      #(limit_ns);
      $display("timeout, the DUT did not finish all transactions in time");
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sys_svc_stimulus.txt
# kind: 0 write, 1 request read, 2 response read, 3 async read, 4 response read then write
# kind src dst len_rd len_wr max_wait error_word(99 none) exp_strobes exp_dones
0 00000000 00000100 0 4 0 99 4 1
1 00000000 00000100 4 0 0 99 4 1
2 00000200 00000000 3 0 2 99 3 1
3 00000300 00000000 5 0 3 99 5 1
4 00000040 00000180 2 3 1 99 5 2
0 00000000 00000100 0 4 4 99 4 1
1 00000000 00000100 4 0 4 99 4 1
2 00000020 00000000 6 0 1 2 2 0
1 00000000 00000180 3 0 0 99 3 1
0 00000000 00000300 0 5 2 3 3 0
3 00000080 00000000 2 0 0 99 2 1

// File: build.f
sys_svc_pkg.sv
xfer_if.sv
ahb_master_fsm.sv
addr_gen.sv
word_counter.sv
sys_svc_ahb_master.sv
tb_sys_svc_ahb_master.sv
